//--- src/mips_pkg.sv
package mips_pkg;

  typedef logic [31:0] word_t;

  // Primary opcodes, bits 31:26 of the instruction word
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_REGIMM  = 6'h01,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_BLEZ    = 6'h06,
    OP_BGTZ    = 6'h07,
    OP_ADDI    = 6'h08,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LB      = 6'h20,
    OP_LH      = 6'h21,
    OP_LW      = 6'h23,
    OP_LBU     = 6'h24,
    OP_LHU     = 6'h25,
    OP_SB      = 6'h28,
    OP_SH      = 6'h29,
    OP_SW      = 6'h2b
  } opcode_t;

  // SPECIAL function codes, bits 5:0
  typedef enum logic [5:0] {
    FUNC_SLL   = 6'h00,
    FUNC_SRL   = 6'h02,
    FUNC_SRA   = 6'h03,
    FUNC_SLLV  = 6'h04,
    FUNC_SRLV  = 6'h06,
    FUNC_SRAV  = 6'h07,
    FUNC_JR    = 6'h08,
    FUNC_JALR  = 6'h09,
    FUNC_MFHI  = 6'h10,
    FUNC_MTHI  = 6'h11,
    FUNC_MFLO  = 6'h12,
    FUNC_MTLO  = 6'h13,
    FUNC_MULT  = 6'h18,
    FUNC_MULTU = 6'h19,
    FUNC_DIV   = 6'h1a,
    FUNC_DIVU  = 6'h1b,
    FUNC_ADD   = 6'h20,
    FUNC_ADDU  = 6'h21,
    FUNC_SUB   = 6'h22,
    FUNC_SUBU  = 6'h23,
    FUNC_AND   = 6'h24,
    FUNC_OR    = 6'h25,
    FUNC_XOR   = 6'h26,
    FUNC_NOR   = 6'h27,
    FUNC_SLT   = 6'h2a,
    FUNC_SLTU  = 6'h2b
  } func_t;

  // REGIMM codes live in the rt field
  typedef enum logic [4:0] {
    REGIMM_BLTZ   = 5'h00,
    REGIMM_BGEZ   = 5'h01,
    REGIMM_BLTZAL = 5'h10,
    REGIMM_BGEZAL = 5'h11
  } regimm_t;

  typedef enum logic [2:0] {
    SRC_ALU_RD,
    SRC_ALU_RT,
    SRC_HI,
    SRC_LO,
    SRC_NONE
  } result_src_t;

  // Store access sizes as reported by the decoder
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  typedef struct packed {
    word_t instr;
    word_t pc;
  } exec_cmd_t;

  typedef struct packed {
    word_t      pc;
    logic       wr_en;
    logic [4:0] dest;
    word_t      value;
    logic       taken;
    word_t      target;
  } exec_result_t;

endpackage

//--- src/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                push_i,
  input  mips_pkg::exec_cmd_t push_data_i,
  input  logic                pop_i,
  output mips_pkg::exec_cmd_t head_o,
  output logic                empty_o,
  output logic                credit_o
);
  import mips_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  exec_cmd_t        mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_pop;

  assign empty_o = (count_q == '0);
  assign head_o  = mem[rd_ptr_q];
  // Popping an empty FIFO is ignored
  assign do_pop  = pop_i && !empty_o;

  // The producer never pushes without a credit, so no full check is needed
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      credit_o <= do_pop;
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- src/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  logic                  fire_i,
  input  mips_pkg::exec_cmd_t   cmd_i,
  output mips_pkg::opcode_t     opcode_o,
  output mips_pkg::func_t       funct_o,
  output mips_pkg::regimm_t     regimm_o,
  output logic [4:0]            rs_idx_o,
  output logic [4:0]            rt_idx_o,
  output logic [15:0]           immediate_o,
  output logic [25:0]           target_o,
  output mips_pkg::word_t       pc_o,
  output logic                  wr_en_o,
  output logic [4:0]            dest_o,
  output mips_pkg::result_src_t src_o,
  output logic                  is_store_o,
  output logic [1:0]            store_size_o
);
  import mips_pkg::*;

  word_t instr;

  // An all-zero word decodes as SLL r0, r0, 0 which serves as the bubble
  assign instr = fire_i ? cmd_i.instr : '0;
  assign pc_o  = fire_i ? cmd_i.pc : '0;

  assign opcode_o    = opcode_t'(instr[31:26]);
  assign rs_idx_o    = instr[25:21];
  assign rt_idx_o    = instr[20:16];
  assign regimm_o    = regimm_t'(instr[20:16]);
  assign immediate_o = instr[15:0];
  assign target_o    = instr[25:0];
  assign funct_o     = func_t'(instr[5:0]);

  always_comb begin
    dest_o       = '0;
    src_o        = SRC_NONE;
    is_store_o   = 1'b0;
    store_size_o = SIZE_WORD;
    if (fire_i) begin
      case (opcode_o)
        OP_SPECIAL: begin
          case (funct_o)
            FUNC_SLL, FUNC_SRL, FUNC_SRA, FUNC_SLLV, FUNC_SRLV, FUNC_SRAV,
            FUNC_ADD, FUNC_ADDU, FUNC_SUB, FUNC_SUBU, FUNC_AND, FUNC_OR,
            FUNC_XOR, FUNC_NOR, FUNC_SLT, FUNC_SLTU, FUNC_JALR: begin
              dest_o = instr[15:11];
              src_o  = SRC_ALU_RD;
            end
            FUNC_MFHI: begin
              dest_o = instr[15:11];
              src_o  = SRC_HI;
            end
            FUNC_MFLO: begin
              dest_o = instr[15:11];
              src_o  = SRC_LO;
            end
            default: ;
          endcase
        end
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
          dest_o = rt_idx_o;
          src_o  = SRC_ALU_RT;
        end
        OP_JAL: begin
          dest_o = 5'd31;
          src_o  = SRC_ALU_RD;
        end
        OP_REGIMM: begin
          // Linking branches write the return address whether taken or not
          if (regimm_o == REGIMM_BLTZAL || regimm_o == REGIMM_BGEZAL) begin
            dest_o = 5'd31;
            src_o  = SRC_ALU_RD;
          end
        end
        OP_SB: begin
          is_store_o   = 1'b1;
          store_size_o = SIZE_BYTE;
        end
        OP_SH: begin
          is_store_o   = 1'b1;
          store_size_o = SIZE_HALF;
        end
        OP_SW: begin
          is_store_o   = 1'b1;
          store_size_o = SIZE_WORD;
        end
        default: ;
      endcase
    end
  end

  assign wr_en_o = (src_o != SRC_NONE);

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic            clk,
  input  logic            reset_i,
  input  logic [4:0]      rs_idx_i,
  input  logic [4:0]      rt_idx_i,
  output mips_pkg::word_t rs_o,
  output mips_pkg::word_t rt_o,
  input  logic            we_i,
  input  logic [4:0]      waddr_i,
  input  mips_pkg::word_t wdata_i
);
  import mips_pkg::*;

  word_t regs [32];

  // Register 0 is hardwired to zero on the read side
  assign rs_o = (rs_idx_i == '0) ? '0 : regs[rs_idx_i];
  assign rt_o = (rt_idx_i == '0) ? '0 : regs[rt_idx_i];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- src/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic              clk,
  input  logic              reset_i,
  input  mips_pkg::opcode_t opcode_i,
  input  mips_pkg::func_t   funct_i,
  input  mips_pkg::regimm_t regimm_i,
  input  mips_pkg::word_t   rs_i,
  input  mips_pkg::word_t   rt_i,
  input  logic [15:0]       immediate_i,
  input  logic [25:0]       target_i,
  input  mips_pkg::word_t   pc_i,
  input  mips_pkg::word_t   ram_readdata_i,
  output logic [1:0]        load_store_byte_offset_o,
  output mips_pkg::word_t   rd_o,
  output mips_pkg::word_t   rt_o,
  output mips_pkg::word_t   effective_address_o,
  output logic              b_cond_met_o,
  output mips_pkg::word_t   mfhi_o,
  output mips_pkg::word_t   mflo_o
);
  import mips_pkg::*;

  logic [63:0] hilo_d;
  logic [63:0] hilo_q;
  word_t       sext_imm;
  word_t       zext_imm;
  word_t       mem_addr;
  word_t       word_addr;
  word_t       next_pc;
  word_t       branch_target;
  word_t       link_addr;
  logic [4:0]  shamt;
  logic [4:0]  shamt_var;
  logic [7:0]  rd_byte;
  logic [15:0] rd_half;

  assign mfhi_o = hilo_q[63:32];
  assign mflo_o = hilo_q[31:0];

  assign sext_imm  = {{16{immediate_i[15]}}, immediate_i};
  assign zext_imm  = {16'b0, immediate_i};
  assign shamt     = immediate_i[10:6];
  assign shamt_var = rs_i[4:0];

  // Branches are relative to the delay slot even though it is not modelled here
  assign next_pc       = pc_i + 32'd4;
  assign branch_target = next_pc + (sext_imm << 2);
  assign link_addr     = pc_i + 32'd8;

  assign mem_addr                 = rs_i + sext_imm;
  assign word_addr                = {mem_addr[31:2], 2'b00};
  assign load_store_byte_offset_o = mem_addr[1:0];

  // Big-endian lanes: offset 0 is the most significant byte of the word
  assign rd_byte = ram_readdata_i[(3 - load_store_byte_offset_o) * 8 +: 8];
  assign rd_half = load_store_byte_offset_o[1] ? ram_readdata_i[15:0] : ram_readdata_i[31:16];

  always_comb begin
    rd_o                = '0;
    rt_o                = '0;
    effective_address_o = '0;
    b_cond_met_o        = 1'b0;
    hilo_d              = hilo_q;

    case (opcode_i)
      OP_SPECIAL: begin
        case (funct_i)
          FUNC_SLL:  rd_o = rt_i << shamt;
          FUNC_SRL:  rd_o = rt_i >> shamt;
          FUNC_SRA:  rd_o = $signed(rt_i) >>> shamt;
          FUNC_SLLV: rd_o = rt_i << shamt_var;
          FUNC_SRLV: rd_o = rt_i >> shamt_var;
          FUNC_SRAV: rd_o = $signed(rt_i) >>> shamt_var;
          // No overflow traps, so the signed forms behave like the unsigned ones
          FUNC_ADD, FUNC_ADDU: rd_o = rs_i + rt_i;
          FUNC_SUB, FUNC_SUBU: rd_o = rs_i - rt_i;
          FUNC_AND:  rd_o = rs_i & rt_i;
          FUNC_OR:   rd_o = rs_i | rt_i;
          FUNC_XOR:  rd_o = rs_i ^ rt_i;
          FUNC_NOR:  rd_o = ~(rs_i | rt_i);
          FUNC_SLT:  rd_o = word_t'($signed(rs_i) < $signed(rt_i));
          FUNC_SLTU: rd_o = word_t'(rs_i < rt_i);
          FUNC_JR: begin
            b_cond_met_o        = 1'b1;
            effective_address_o = rs_i;
          end
          FUNC_JALR: begin
            rd_o                = link_addr;
            b_cond_met_o        = 1'b1;
            effective_address_o = rs_i;
          end
          FUNC_MULT:  hilo_d = $signed(rs_i) * $signed(rt_i);
          FUNC_MULTU: hilo_d = rs_i * rt_i;
          // HI takes the remainder and LO the quotient
          FUNC_DIV: begin
            if (rt_i == '0) begin
              hilo_d = '0;
            end else begin
              hilo_d = {word_t'($signed(rs_i) % $signed(rt_i)),
                        word_t'($signed(rs_i) / $signed(rt_i))};
            end
          end
          FUNC_DIVU: begin
            if (rt_i == '0) begin
              hilo_d = '0;
            end else begin
              hilo_d = {rs_i % rt_i, rs_i / rt_i};
            end
          end
          FUNC_MTHI: hilo_d = {rs_i, hilo_q[31:0]};
          FUNC_MTLO: hilo_d = {hilo_q[63:32], rs_i};
          default: ;
        endcase
      end

      OP_ADDI, OP_ADDIU: rt_o = rs_i + sext_imm;
      OP_SLTI:  rt_o = word_t'($signed(rs_i) < $signed(sext_imm));
      // SLTIU compares against the sign-extended immediate as an unsigned number
      OP_SLTIU: rt_o = word_t'(rs_i < sext_imm);
      OP_ANDI:  rt_o = rs_i & zext_imm;
      OP_ORI:   rt_o = rs_i | zext_imm;
      OP_XORI:  rt_o = rs_i ^ zext_imm;
      OP_LUI:   rt_o = {immediate_i, 16'b0};

      OP_LW: begin
        effective_address_o = word_addr;
        rt_o                = ram_readdata_i;
      end
      OP_LH: begin
        effective_address_o = word_addr;
        rt_o                = {{16{rd_half[15]}}, rd_half};
      end
      OP_LHU: begin
        effective_address_o = word_addr;
        rt_o                = {16'b0, rd_half};
      end
      OP_LB: begin
        effective_address_o = word_addr;
        rt_o                = {{24{rd_byte[7]}}, rd_byte};
      end
      OP_LBU: begin
        effective_address_o = word_addr;
        rt_o                = {24'b0, rd_byte};
      end

      // Store data leaves already placed in its byte lane
      OP_SW: begin
        effective_address_o = word_addr;
        rt_o                = rt_i;
      end
      OP_SH: begin
        effective_address_o = word_addr;
        rt_o = load_store_byte_offset_o[1] ? {16'b0, rt_i[15:0]} : {rt_i[15:0], 16'b0};
      end
      OP_SB: begin
        effective_address_o = word_addr;
        rt_o                = word_t'(rt_i[7:0]) << ((3 - load_store_byte_offset_o) * 8);
      end

      OP_BEQ: begin
        b_cond_met_o        = (rs_i == rt_i);
        effective_address_o = branch_target;
      end
      OP_BNE: begin
        b_cond_met_o        = (rs_i != rt_i);
        effective_address_o = branch_target;
      end
      OP_BLEZ: begin
        b_cond_met_o        = ($signed(rs_i) <= 0);
        effective_address_o = branch_target;
      end
      OP_BGTZ: begin
        b_cond_met_o        = ($signed(rs_i) > 0);
        effective_address_o = branch_target;
      end

      OP_REGIMM: begin
        case (regimm_i)
          REGIMM_BLTZ, REGIMM_BLTZAL: b_cond_met_o = rs_i[31];
          REGIMM_BGEZ, REGIMM_BGEZAL: b_cond_met_o = !rs_i[31];
          default: ;
        endcase
        if (regimm_i == REGIMM_BLTZAL || regimm_i == REGIMM_BGEZAL) begin
          rd_o = link_addr;
        end
        effective_address_o = branch_target;
      end

      // Region jumps keep the top four bits of the delay slot address
      OP_J: begin
        b_cond_met_o        = 1'b1;
        effective_address_o = {next_pc[31:28], target_i, 2'b00};
      end
      OP_JAL: begin
        b_cond_met_o        = 1'b1;
        effective_address_o = {next_pc[31:28], target_i, 2'b00};
        rd_o                = link_addr;
      end

      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      hilo_q <= '0;
    end else begin
      hilo_q <= hilo_d;
    end
  end

endmodule

//--- src/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic            clk,
  input  mips_pkg::word_t addr_i,
  output mips_pkg::word_t rdata_o,
  input  logic            we_i,
  input  logic [3:0]      byte_en_i,
  input  mips_pkg::word_t wdata_i
);
  import mips_pkg::*;

  localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  word_t         mem [RAM_WORDS];
  logic [AW-1:0] word_idx;

  // Byte address to word index, upper bits wrap around
  assign word_idx = addr_i[AW+1:2];
  assign rdata_o  = mem[word_idx];

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // byte_en_i[3] covers bits 31:24, which is byte offset 0
  always_ff @(posedge clk) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en_i[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- src/exec_core.sv
`timescale 1ns/1ps

module exec_core #(
  parameter int FIFO_DEPTH  = 4,
  parameter int OUT_CREDITS = 2,
  parameter int RAM_WORDS   = 256
) (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   cmd_valid_i,
  input  mips_pkg::exec_cmd_t    cmd_i,
  output logic                   in_credit_o,
  output logic                   res_valid_o,
  output mips_pkg::exec_result_t res_o,
  input  logic                   res_credit_i
);
  import mips_pkg::*;

  localparam int CW = $clog2(OUT_CREDITS + 1);

  exec_cmd_t     head;
  logic          fifo_empty;
  logic          pop;
  logic [CW-1:0] out_credits_q;

  opcode_t       opcode;
  func_t         funct;
  regimm_t       regimm;
  logic [4:0]    rs_idx;
  logic [4:0]    rt_idx;
  logic [15:0]   immediate;
  logic [25:0]   target;
  word_t         pc;
  logic          wr_en;
  logic [4:0]    dest;
  result_src_t   src;
  logic          is_store;
  logic [1:0]    store_size;

  word_t         rs_val;
  word_t         rt_val;
  word_t         ram_rdata;
  logic [1:0]    byte_off;
  word_t         alu_rd;
  word_t         alu_rt;
  word_t         eff_addr;
  logic          taken;
  word_t         hi_val;
  word_t         lo_val;
  word_t         wb_value;
  logic [3:0]    byte_en;

  // One instruction per cycle while a command waits and the consumer has room
  assign pop = !fifo_empty && (out_credits_q != '0);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      out_credits_q <= CW'(OUT_CREDITS);
    end else begin
      out_credits_q <= out_credits_q - CW'(pop) + CW'(res_credit_i);
    end
  end

  cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) i_cmd_fifo (
    .clk        (clk),
    .reset_i    (reset_i),
    .push_i     (cmd_valid_i),
    .push_data_i(cmd_i),
    .pop_i      (pop),
    .head_o     (head),
    .empty_o    (fifo_empty),
    .credit_o   (in_credit_o)
  );

  instr_decoder i_instr_decoder (
    .fire_i      (pop),
    .cmd_i       (head),
    .opcode_o    (opcode),
    .funct_o     (funct),
    .regimm_o    (regimm),
    .rs_idx_o    (rs_idx),
    .rt_idx_o    (rt_idx),
    .immediate_o (immediate),
    .target_o    (target),
    .pc_o        (pc),
    .wr_en_o     (wr_en),
    .dest_o      (dest),
    .src_o       (src),
    .is_store_o  (is_store),
    .store_size_o(store_size)
  );

  reg_file i_reg_file (
    .clk     (clk),
    .reset_i (reset_i),
    .rs_idx_i(rs_idx),
    .rt_idx_i(rt_idx),
    .rs_o    (rs_val),
    .rt_o    (rt_val),
    .we_i    (wr_en),
    .waddr_i (dest),
    .wdata_i (wb_value)
  );

  alu i_alu (
    .clk                     (clk),
    .reset_i                 (reset_i),
    .opcode_i                (opcode),
    .funct_i                 (funct),
    .regimm_i                (regimm),
    .rs_i                    (rs_val),
    .rt_i                    (rt_val),
    .immediate_i             (immediate),
    .target_i                (target),
    .pc_i                    (pc),
    .ram_readdata_i          (ram_rdata),
    .load_store_byte_offset_o(byte_off),
    .rd_o                    (alu_rd),
    .rt_o                    (alu_rt),
    .effective_address_o     (eff_addr),
    .b_cond_met_o            (taken),
    .mfhi_o                  (hi_val),
    .mflo_o                  (lo_val)
  );

  // Lane 3 of the enable is byte offset 0, the most significant byte
  always_comb begin
    case (store_size)
      SIZE_BYTE: byte_en = 4'b1000 >> byte_off;
      SIZE_HALF: byte_en = byte_off[1] ? 4'b0011 : 4'b1100;
      default:   byte_en = 4'b1111;
    endcase
  end

  data_ram #(
    .RAM_WORDS(RAM_WORDS)
  ) i_data_ram (
    .clk      (clk),
    .addr_i   (eff_addr),
    .rdata_o  (ram_rdata),
    .we_i     (is_store),
    .byte_en_i(byte_en),
    .wdata_i  (alu_rt)
  );

  always_comb begin
    case (src)
      SRC_ALU_RD: wb_value = alu_rd;
      SRC_ALU_RT: wb_value = alu_rt;
      SRC_HI:     wb_value = hi_val;
      SRC_LO:     wb_value = lo_val;
      default:    wb_value = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= pop;
    end
  end

  // The packet is captured on the same edge that commits the instruction
  always_ff @(posedge clk) begin
    if (pop) begin
      res_o <= '{pc: pc, wr_en: wr_en, dest: dest, value: wb_value,
                 taken: taken, target: eff_addr};
    end
  end

endmodule

//--- dv/exec_core_tb.sv
`timescale 1ns/1ps

module exec_core_tb;
  import mips_pkg::*;

  localparam int FIFO_DEPTH     = 4;
  localparam int OUT_CREDITS    = 2;
  localparam int RAM_WORDS      = 256;
  localparam int NUM_VEC        = 47;
  localparam int COLS           = 7;
  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 50 * NUM_VEC;

  // The consumer returns no credits inside this window, which backs up the FIFO
  localparam int HOLD_START = 30;
  localparam int HOLD_END   = 90;

  logic         clk;
  logic         reset_i;
  logic         cmd_valid_i;
  exec_cmd_t    cmd_i;
  logic         in_credit_o;
  logic         res_valid_o;
  exec_result_t res_o;
  logic         res_credit_i;

  // Seven words per instruction, columns as listed at the top of the vector file
  logic [31:0] vec_mem [NUM_VEC * COLS];
  integer      seed;
  logic [31:0] rnd;
  int          error_count;
  int          sent;
  int          checked;
  int          in_credits;
  int          in_credit_total;
  int          pending;
  int          cycle;

  exec_core #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .OUT_CREDITS(OUT_CREDITS),
    .RAM_WORDS  (RAM_WORDS)
  ) i_dut (
    .clk         (clk),
    .reset_i     (reset_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .in_credit_o (in_credit_o),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_credit_i(res_credit_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input int idx, input string name,
                                 input logic [31:0] exp, input logic [31:0] got);
    error_count++;
    $display("error: vector %0d %s expected 0x%08h got 0x%08h", idx, name, exp, got);
  endtask

  task automatic check_result(input int idx);
    int base;
    base = idx * COLS;
    if (res_o.pc !== vec_mem[base + 1]) begin
      report_mismatch(idx, "res_o.pc", vec_mem[base + 1], res_o.pc);
    end
    if (res_o.wr_en !== vec_mem[base + 2][0]) begin
      report_mismatch(idx, "res_o.wr_en", vec_mem[base + 2], {31'b0, res_o.wr_en});
    end
    if (res_o.dest !== vec_mem[base + 3][4:0]) begin
      report_mismatch(idx, "res_o.dest", vec_mem[base + 3], {27'b0, res_o.dest});
    end
    if (res_o.value !== vec_mem[base + 4]) begin
      report_mismatch(idx, "res_o.value", vec_mem[base + 4], res_o.value);
    end
    if (res_o.taken !== vec_mem[base + 5][0]) begin
      report_mismatch(idx, "res_o.taken", vec_mem[base + 5], {31'b0, res_o.taken});
    end
    if (res_o.target !== vec_mem[base + 6]) begin
      report_mismatch(idx, "res_o.target", vec_mem[base + 6], res_o.target);
    end
  endtask

  // Registered DUT outputs still hold last cycle's values when this runs at the edge
  task automatic observe_outputs();
    if (in_credit_o) begin
      in_credits++;
      in_credit_total++;
    end
    if (in_credits > FIFO_DEPTH) begin
      error_count++;
      $display("producer holds %0d input credits, more than the FIFO depth", in_credits);
    end
    if (res_valid_o) begin
      if (checked < NUM_VEC) begin
        check_result(checked);
      end else begin
        error_count++;
        $display("a result arrived after the last expected instruction");
      end
      checked++;
      pending++;
      if (pending > OUT_CREDITS) begin
        error_count++;
        $display("%0d results outstanding, more than the output credits", pending);
      end
    end
  endtask

  task automatic drive_command();
    rnd = $random(seed);
    if (sent < NUM_VEC && in_credits > 0 && rnd[1:0] != 2'b00) begin
      cmd_valid_i <= 1'b1;
      cmd_i.instr <= vec_mem[sent * COLS];
      cmd_i.pc    <= vec_mem[sent * COLS + 1];
      in_credits--;
      sent++;
    end else begin
      cmd_valid_i <= 1'b0;
    end
  endtask

  task automatic return_credit();
    rnd = $random(seed);
    if (pending > 0 && !(cycle >= HOLD_START && cycle < HOLD_END) && rnd[0]) begin
      res_credit_i <= 1'b1;
      pending--;
    end else begin
      res_credit_i <= 1'b0;
    end
  endtask

  initial begin
    clk             = 1'b0;
    reset_i         = 1'b1;
    cmd_valid_i     = 1'b0;
    cmd_i           = '0;
    res_credit_i    = 1'b0;
    seed            = 99;
    error_count     = 0;
    sent            = 0;
    checked         = 0;
    in_credits      = FIFO_DEPTH;
    in_credit_total = 0;
    pending         = 0;
    cycle           = 0;
    $readmemh("dv/exec_vectors.txt", vec_mem);

    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;

    while (checked < NUM_VEC) begin
      @(posedge clk);
      cycle++;
      observe_outputs();
      drive_command();
      return_credit();
    end

    // Idle cycles catch any extra result or credit pulse
    repeat (5) begin
      @(posedge clk);
      cycle++;
      observe_outputs();
      cmd_valid_i <= 1'b0;
      return_credit();
    end
    if (in_credit_total != NUM_VEC) begin
      error_count++;
      $display("saw %0d input credit pulses for %0d commands", in_credit_total, NUM_VEC);
    end

    $display("results checked: %0d, errors: %0d", checked, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, %0d of %0d results seen",
             TIMEOUT_CYCLES, checked, NUM_VEC);
    $display("results checked: %0d, errors: %0d", checked, error_count);
    $display("test failed");
    $finish;
  end

endmodule

//--- dv/exec_vectors.txt
// Columns: instr pc wr_en dest value taken target, all in hex
// ALU results, each one feeding later instructions
24011234 00001000 1 01 00001234 0 00000000
2402fffd 00001004 1 02 fffffffd 0 00000000
3423f0f0 00001008 1 03 0000f2f4 0 00000000
3c048001 0000100c 1 04 80010000 0 00000000
00032900 00001010 1 05 000f2f40 0 00000000
00443007 00001014 1 06 fffffffc 0 00000000
00233823 00001018 1 07 ffff1f40 0 00000000
00224027 0000101c 1 08 00000002 0 00000000
0041482a 00001020 1 09 00000001 0 00000000
2c2affff 00001024 1 0a 00000001 0 00000000
// Multiply and divide through HI/LO, the last divide is by zero
00430018 00001028 0 00 00000000 0 00000000
00005810 0000102c 1 0b ffffffff 0 00000000
00006012 00001030 1 0c fffd2724 0 00000000
0061001b 00001034 0 00 00000000 0 00000000
00006810 00001038 1 0d 00000650 0 00000000
00007012 0000103c 1 0e 0000000d 0 00000000
0020001b 00001040 0 00 00000000 0 00000000
00007810 00001044 1 0f 00000000 0 00000000
00008012 00001048 1 10 00000000 0 00000000
// Stores and loads on the word at 0x100, big-endian lanes
24110100 0000104c 1 11 00000100 0 00000000
3c128122 00001050 1 12 81220000 0 00000000
365233c4 00001054 1 12 812233c4 0 00000000
ae320000 00001058 0 00 00000000 0 00000100
8e330000 0000105c 1 13 812233c4 0 00000100
82340000 00001060 1 14 ffffff81 0 00000100
92350001 00001064 1 15 00000022 0 00000100
82360003 00001068 1 16 ffffffc4 0 00000100
92370002 0000106c 1 17 00000033 0 00000100
86380000 00001070 1 18 ffff8122 0 00000100
96390002 00001074 1 19 000033c4 0 00000100
a6210002 00001078 0 00 00000000 0 00000100
a2220001 0000107c 0 00 00000000 0 00000100
a22e0003 00001080 0 00 00000000 0 00000100
8e3a0000 00001084 1 1a 81fd120d 0 00000100
863b0002 00001088 1 1b 0000120d 0 00000100
963c0000 0000108c 1 1c 000081fd 0 00000100
// Branches, jumps and links
10210010 00001090 0 00 00000000 1 000010d4
1421fffc 00001094 0 00 00000000 0 00001088
18400008 00001098 0 00 00000000 1 000010bc
1c400008 0000109c 0 00 00000000 0 000010c0
04200002 000010a0 0 00 00000000 0 000010ac
04210002 000010a4 0 00 00000000 1 000010b0
08123456 9ffffffc 0 00 00000000 1 a048d158
0c000400 000010ac 1 1f 000010b4 1 00001000
02200008 000010b0 0 00 00000000 1 00000100
04510004 000010b4 1 1f 000010bc 0 000010c8
03e0e821 000010b8 1 1d 000010bc 0 00000000

//--- project.f
src/mips_pkg.sv
src/cmd_fifo.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/data_ram.sv
src/exec_core.sv
dv/exec_core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f project.f --top-module exec_core_tb -o exec_core_sim
out=$(./obj_dir/exec_core_sim)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
  exit 0
else
  exit 1
fi
